//--- src/ooo_types_pkg.sv
package ooo_types_pkg;

    // Datapath and tag widths
    localparam int DATA_W = 32;
    localparam int TAG_W = 4;
    localparam int OP_W = 3;

    // One operand or result word
    typedef logic [DATA_W-1:0] data_t;
    // Destination tag, room for up to 16 in-flight results
    typedef logic [TAG_W-1:0] tag_t;
    // Operation code, only OP_MUL goes to the multiplier
    typedef logic [OP_W-1:0] opcode_t;

    localparam opcode_t OP_ADD = 3'd0;
    localparam opcode_t OP_SUB = 3'd1;
    localparam opcode_t OP_AND = 3'd2;
    localparam opcode_t OP_OR = 3'd3;
    localparam opcode_t OP_XOR = 3'd4;
    // Signed compare, result is 1 or 0
    localparam opcode_t OP_SLT = 3'd5;
    // Low word of the product
    localparam opcode_t OP_MUL = 3'd6;

    // Source operand
    // When ready is low the value is junk and tag names the producer
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } src_operand_t;

    // Instruction handed from dispatch to the station
    typedef struct packed {
        opcode_t      op;
        src_operand_t src1;
        src_operand_t src2;
        tag_t         dest;
    } dispatch_inst_t;

    // Request issued from the station to one execution unit
    typedef struct packed {
        logic    valid;
        opcode_t op;
        data_t   operand_a;
        data_t   operand_b;
        tag_t    dest;
    } exec_req_t;

    // Unit result, also the common data bus itself
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } cdb_t;

    // Operand capture from the bus
    // A waiting source whose producer broadcasts now takes the value
    function automatic src_operand_t snoop_cdb(src_operand_t src, cdb_t bus);
        src_operand_t captured;
        captured = src;
        if (!src.ready && bus.valid && (bus.tag == src.tag)) begin
            captured.ready = 1'b1;
            captured.value = bus.value;
        end
        return captured;
    endfunction

endpackage

//--- src/tag_allocator.sv
module tag_allocator #(
    parameter int NUM_TAGS = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 claim,
    input  ooo_types_pkg::cdb_t  cdb,
    output ooo_types_pkg::tag_t  free_tag,
    output logic                 any_free
);

    import ooo_types_pkg::*;

    // One bit per tag, set while its result is still in flight
    logic [NUM_TAGS-1:0] busy;

    // Priority pick of the lowest clear bit
    // Scanning downwards lets the lowest index win
    always_comb begin
        free_tag = '0;
        any_free = 1'b0;
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_tag = tag_t'(i);
                any_free = 1'b1;
            end
        end
    end

    // Release on broadcast, set on claim
    // A tag released this cycle is still busy in the bitmap,
    // so it cannot be the one offered in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                if (cdb.valid && (cdb.tag == tag_t'(i))) begin
                    busy[i] <= 1'b0;
                end
                // Claim without a free tag is ignored, stall prevents it
                if (claim && any_free && (free_tag == tag_t'(i))) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/dispatch_stage.sv
module dispatch_stage #(
    parameter int NUM_TAGS = 8,
    parameter int RS_ENTRIES = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                inst_valid,
    input  ooo_types_pkg::opcode_t              inst_op,
    input  ooo_types_pkg::src_operand_t         inst_src1,
    input  ooo_types_pkg::src_operand_t         inst_src2,
    input  ooo_types_pkg::cdb_t                 cdb,
    input  logic [$clog2(RS_ENTRIES+1)-1:0]     rs_free_count,
    output ooo_types_pkg::dispatch_inst_t       dispatch_out,
    output logic                                dispatch_valid,
    output ooo_types_pkg::tag_t                 issue_tag,
    output logic                                stall
);

    import ooo_types_pkg::*;

    localparam int CNT_W = $clog2(RS_ENTRIES + 1);

    tag_t             free_tag;
    logic             any_free;
    // Station entries needed, the pending one plus a new strobe
    logic [CNT_W:0]   entries_needed;

    // Every strobe claims the tag offered this cycle
    tag_allocator #(
        .NUM_TAGS (NUM_TAGS)
    ) i_tag_allocator (
        .clk      (clk),
        .rst      (rst),
        .claim    (inst_valid),
        .cdb      (cdb),
        .free_tag (free_tag),
        .any_free (any_free)
    );

    // Tag is visible to the outside during the strobe cycle
    assign issue_tag = free_tag;

    // Register the instruction
    // Sources produced on the bus this cycle are captured here
    always_ff @(posedge clk) begin
        dispatch_out.op   <= inst_op;
        dispatch_out.src1 <= snoop_cdb(inst_src1, cdb);
        dispatch_out.src2 <= snoop_cdb(inst_src2, cdb);
        dispatch_out.dest <= free_tag;
        if (rst) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= inst_valid;
        end
    end

    // Registered instruction is not yet in the station count
    assign entries_needed = (CNT_W + 1)'(1) + (CNT_W + 1)'(dispatch_valid);

    // Hold off on an empty pool or when the station would overflow
    assign stall = !any_free || ({1'b0, rs_free_count} < entries_needed);

endmodule

//--- src/reservation_station.sv
module reservation_station #(
    parameter int RS_ENTRIES = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  ooo_types_pkg::dispatch_inst_t    dispatch_in,
    input  logic                             dispatch_valid,
    input  ooo_types_pkg::cdb_t              cdb,
    input  logic                             alu_room,
    output ooo_types_pkg::exec_req_t         alu_req,
    output ooo_types_pkg::exec_req_t         mult_req,
    output logic [$clog2(RS_ENTRIES+1)-1:0]  free_count
);

    import ooo_types_pkg::*;

    localparam int CNT_W = $clog2(RS_ENTRIES + 1);
    localparam int IDX_W = (RS_ENTRIES > 1) ? $clog2(RS_ENTRIES) : 1;

    // Entry table, values travel with the entry
    logic [RS_ENTRIES-1:0] entry_valid;
    dispatch_inst_t        entry [RS_ENTRIES];

    // Issue pick
    logic                  sel_found;
    logic [IDX_W-1:0]      sel_idx;
    logic                  sel_is_mul;
    exec_req_t             sel_req;

    // Insert slot
    logic                  ins_found;
    logic [IDX_W-1:0]      ins_idx;

    always_comb begin
        sel_found = 1'b0;
        sel_idx = '0;
        ins_found = 1'b0;
        ins_idx = '0;
        free_count = '0;
        // Downward scan so the lowest index ends up chosen
        for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
            // Both operands present and the target unit can take it
            // ALU entries hold back while the writeback queue is short of room
            if (entry_valid[i] && entry[i].src1.ready && entry[i].src2.ready &&
                ((entry[i].op == OP_MUL) || alu_room)) begin
                sel_found = 1'b1;
                sel_idx = IDX_W'(i);
            end
            if (!entry_valid[i]) begin
                ins_found = 1'b1;
                ins_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (!entry_valid[i]) begin
                free_count = free_count + CNT_W'(1);
            end
        end
    end

    // Request built from the picked entry
    assign sel_is_mul = (entry[sel_idx].op == OP_MUL);
    assign sel_req.valid = sel_found;
    assign sel_req.op = entry[sel_idx].op;
    assign sel_req.operand_a = entry[sel_idx].src1.value;
    assign sel_req.operand_b = entry[sel_idx].src2.value;
    assign sel_req.dest = entry[sel_idx].dest;

    // Request registers, one unit per cycle at most
    always_ff @(posedge clk) begin
        alu_req <= sel_req;
        mult_req <= sel_req;
        alu_req.valid <= sel_found && !sel_is_mul;
        mult_req.valid <= sel_found && sel_is_mul;
        if (rst) begin
            alu_req.valid <= 1'b0;
            mult_req.valid <= 1'b0;
        end
    end

    // Entry payload and wakeup
    always_ff @(posedge clk) begin
        // Waiting sources snoop the bus every cycle
        for (int i = 0; i < RS_ENTRIES; i++) begin
            entry[i].src1 <= snoop_cdb(entry[i].src1, cdb);
            entry[i].src2 <= snoop_cdb(entry[i].src2, cdb);
        end
        // New instruction also snoops on its way in
        if (dispatch_valid && ins_found) begin
            entry[ins_idx].op <= dispatch_in.op;
            entry[ins_idx].src1 <= snoop_cdb(dispatch_in.src1, cdb);
            entry[ins_idx].src2 <= snoop_cdb(dispatch_in.src2, cdb);
            entry[ins_idx].dest <= dispatch_in.dest;
        end
    end

    // Occupancy
    // The issued slot opens now but is only reused next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            if (sel_found) begin
                entry_valid[sel_idx] <= 1'b0;
            end
            if (dispatch_valid && ins_found) begin
                entry_valid[ins_idx] <= 1'b1;
            end
        end
    end

endmodule

//--- src/alu_unit.sv
module alu_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  ooo_types_pkg::exec_req_t   req,
    output ooo_types_pkg::cdb_t        result
);

    import ooo_types_pkg::*;

    data_t alu_out;
    logic  less_than;

    // Signed compare for set-less-than
    assign less_than = $signed(req.operand_a) < $signed(req.operand_b);

    always_comb begin
        case (req.op)
            OP_ADD: begin
                alu_out = req.operand_a + req.operand_b;
            end
            OP_SUB: begin
                alu_out = req.operand_a - req.operand_b;
            end
            OP_AND: begin
                alu_out = req.operand_a & req.operand_b;
            end
            OP_OR: begin
                alu_out = req.operand_a | req.operand_b;
            end
            OP_XOR: begin
                alu_out = req.operand_a ^ req.operand_b;
            end
            OP_SLT: begin
                alu_out = data_t'(less_than);
            end
            // Multiplies never arrive here
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // Result register, one edge after the request
    always_ff @(posedge clk) begin
        result.tag <= req.dest;
        result.value <= alu_out;
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= req.valid;
        end
    end

endmodule

//--- src/mult_unit.sv
module mult_unit #(
    parameter int MULT_STAGES = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  ooo_types_pkg::exec_req_t   req,
    output ooo_types_pkg::cdb_t        result
);

    import ooo_types_pkg::*;

    // Low word only, upper product bits are dropped
    data_t product;
    // Pipeline, one new product may enter each cycle
    cdb_t  stage_q [MULT_STAGES];

    assign product = req.operand_a * req.operand_b;

    always_ff @(posedge clk) begin
        // First stage forms the product
        stage_q[0].tag <= req.dest;
        stage_q[0].value <= product;
        stage_q[0].valid <= req.valid;
        // Later stages just carry it along
        for (int i = 1; i < MULT_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
        if (rst) begin
            for (int i = 0; i < MULT_STAGES; i++) begin
                stage_q[i].valid <= 1'b0;
            end
        end
    end

    // Last stage, MULT_STAGES edges after the request
    assign result = stage_q[MULT_STAGES-1];

endmodule

//--- src/writeback_arbiter.sv
module writeback_arbiter #(
    parameter int ALU_QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_types_pkg::cdb_t  alu_result,
    input  ooo_types_pkg::cdb_t  mult_result,
    output ooo_types_pkg::cdb_t  cdb,
    output logic                 alu_room
);

    import ooo_types_pkg::*;

    localparam int PTR_W = (ALU_QUEUE_DEPTH > 1) ? $clog2(ALU_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(ALU_QUEUE_DEPTH + 1);

    // ALU result FIFO
    cdb_t             queue [ALU_QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             queue_empty;
    logic             push;
    logic             pop;
    int               slots_left;

    assign queue_empty = (count == '0);

    // Multiplier first, then the oldest queued ALU result,
    // then a fresh ALU result straight through
    always_comb begin
        if (mult_result.valid) begin
            cdb = mult_result;
        end else if (!queue_empty) begin
            cdb = queue[rd_ptr];
        end else begin
            cdb = alu_result;
        end
    end

    // ALU result that is not broadcast now waits in the queue
    assign push = alu_result.valid && (mult_result.valid || !queue_empty);
    assign pop = !mult_result.valid && !queue_empty;

    // Room counts the arriving result as queued already
    // Two slots cover the request inside the ALU and one new issue
    always_comb begin
        slots_left = ALU_QUEUE_DEPTH - int'(count) - int'(push);
        alu_room = (slots_left >= 2);
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(ALU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(ALU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

//--- src/ooo_issue_top.sv
module ooo_issue_top #(
    parameter int NUM_TAGS = 8,
    parameter int RS_ENTRIES = 8,
    parameter int MULT_STAGES = 3,
    parameter int ALU_QUEUE_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_valid,
    input  ooo_types_pkg::opcode_t       inst_op,
    input  ooo_types_pkg::src_operand_t  inst_src1,
    input  ooo_types_pkg::src_operand_t  inst_src2,
    output ooo_types_pkg::tag_t          issue_tag,
    output logic                         stall,
    output ooo_types_pkg::cdb_t          cdb
);

    import ooo_types_pkg::*;

    localparam int CNT_W = $clog2(RS_ENTRIES + 1);

    // Dispatch to station
    dispatch_inst_t   dispatch_inst;
    logic             dispatch_valid;
    logic [CNT_W-1:0] rs_free_count;
    // Station to units
    exec_req_t        alu_req;
    exec_req_t        mult_req;
    logic             alu_room;
    // Units to writeback
    cdb_t             alu_result;
    cdb_t             mult_result;

    dispatch_stage #(
        .NUM_TAGS   (NUM_TAGS),
        .RS_ENTRIES (RS_ENTRIES)
    ) i_dispatch_stage (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_op        (inst_op),
        .inst_src1      (inst_src1),
        .inst_src2      (inst_src2),
        .cdb            (cdb),
        .rs_free_count  (rs_free_count),
        .dispatch_out   (dispatch_inst),
        .dispatch_valid (dispatch_valid),
        .issue_tag      (issue_tag),
        .stall          (stall)
    );

    reservation_station #(
        .RS_ENTRIES (RS_ENTRIES)
    ) i_reservation_station (
        .clk            (clk),
        .rst            (rst),
        .dispatch_in    (dispatch_inst),
        .dispatch_valid (dispatch_valid),
        .cdb            (cdb),
        .alu_room       (alu_room),
        .alu_req        (alu_req),
        .mult_req       (mult_req),
        .free_count     (rs_free_count)
    );

    alu_unit i_alu_unit (
        .clk    (clk),
        .rst    (rst),
        .req    (alu_req),
        .result (alu_result)
    );

    mult_unit #(
        .MULT_STAGES (MULT_STAGES)
    ) i_mult_unit (
        .clk    (clk),
        .rst    (rst),
        .req    (mult_req),
        .result (mult_result)
    );

    // Single broadcast bus back to dispatch, station and the outside
    writeback_arbiter #(
        .ALU_QUEUE_DEPTH (ALU_QUEUE_DEPTH)
    ) i_writeback_arbiter (
        .clk         (clk),
        .rst         (rst),
        .alu_result  (alu_result),
        .mult_result (mult_result),
        .cdb         (cdb),
        .alu_room    (alu_room)
    );

endmodule

//--- sim/tb_ooo_issue_top.sv
module tb_ooo_issue_top;

    import ooo_types_pkg::*;

    localparam int NUM_TAGS = 8;
    localparam int STIM_CYCLES = 600;
    localparam int DRAIN_LIMIT = 400;
    localparam int IDLE_CYCLES = 20;

    logic         clk;
    logic         rst;
    logic         inst_valid;
    opcode_t      inst_op;
    src_operand_t inst_src1;
    src_operand_t inst_src2;
    tag_t         issue_tag;
    logic         stall;
    cdb_t         cdb;

    // Reference model with one record per tag
    logic         outstanding [NUM_TAGS];
    opcode_t      model_op [NUM_TAGS];
    src_operand_t model_src1 [NUM_TAGS];
    src_operand_t model_src2 [NUM_TAGS];

    logic [31:0]  lcg_state;
    int           error_count;
    int           check_count;
    int           strobe_count;
    int           broadcast_count;

    ooo_issue_top i_ooo_issue_top (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_op    (inst_op),
        .inst_src1  (inst_src1),
        .inst_src2  (inst_src2),
        .issue_tag  (issue_tag),
        .stall      (stall),
        .cdb        (cdb)
    );

    always #20 clk = ~clk;

    // Plain LCG
    // Low bits are weak so callers use the upper half
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return (next_rand() >> 16) % n;
    endfunction

    function automatic data_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    // Everything the ALU can do, picked by an index from 0 to 5
    function automatic opcode_t alu_op_at(int unsigned idx);
        case (idx)
            0: return OP_ADD;
            1: return OP_SUB;
            2: return OP_AND;
            3: return OP_OR;
            4: return OP_XOR;
            default: return OP_SLT;
        endcase
    endfunction

    // Operation rules of the back end
    function automatic data_t expected_result(opcode_t op, data_t a, data_t b);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR:  return a | b;
            OP_XOR: return a ^ b;
            OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            // Low word of the product
            OP_MUL: return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic int count_outstanding();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (outstanding[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    // Random ready value or a dependency on some result still in flight
    function automatic src_operand_t pick_source();
        src_operand_t src;
        tag_t         pool [$];
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (outstanding[t]) begin
                pool.push_back(tag_t'(t));
            end
        end
        src.ready = 1'b1;
        src.tag = tag_t'(rand_below(16));
        src.value = rand_word();
        // Value stays as junk when the source waits
        if (pool.size() > 0 && rand_below(2) == 0) begin
            src.ready = 1'b0;
            src.tag = pool[rand_below(pool.size())];
        end
        return src;
    endfunction

    // Hand a broadcast value to every model source waiting on that tag
    task automatic wake_sources(tag_t tag, data_t value);
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (outstanding[t] && !model_src1[t].ready && model_src1[t].tag == tag) begin
                model_src1[t].ready = 1'b1;
                model_src1[t].value = value;
            end
            if (outstanding[t] && !model_src2[t].ready && model_src2[t].tag == tag) begin
                model_src2[t].ready = 1'b1;
                model_src2[t].value = value;
            end
        end
    endtask

    // Called just after the rising edge
    task automatic drive_inputs(bit allow);
        inst_valid = 1'b0;
        // Strobe only while stall is low, about 70% of those cycles
        if (allow && !stall && rand_below(10) < 7) begin
            inst_valid = 1'b1;
            if (rand_below(3) == 0) begin
                inst_op = OP_MUL;
            end else begin
                inst_op = alu_op_at(rand_below(6));
            end
            inst_src1 = pick_source();
            inst_src2 = pick_source();
        end
    endtask

    // Called at the falling edge when every output has settled
    task automatic monitor_cycle();
        tag_t  t;
        data_t expected;
        // Full tag pool must hold off the outside
        if (count_outstanding() == NUM_TAGS) begin
            check_count++;
            assert (stall) else begin
                error_count++;
                $display("ERROR time=%0t signal=stall expected=1 actual=%b", $time, stall);
            end
        end
        // New strobe goes into the model before this cycle's broadcast
        // Dispatch also captures a source that is broadcast right now
        if (inst_valid) begin
            t = issue_tag;
            check_count++;
            assert (int'(t) < NUM_TAGS && !outstanding[t]) else begin
                error_count++;
                $display("At time %0t a strobe received tag %0d, which is busy or out of range",
                         $time, t);
            end
            if (int'(t) < NUM_TAGS) begin
                outstanding[t] = 1'b1;
                model_op[t] = inst_op;
                model_src1[t] = inst_src1;
                model_src2[t] = inst_src2;
                strobe_count++;
            end
        end
        if (cdb.valid) begin
            t = cdb.tag;
            check_count++;
            assert (int'(t) < NUM_TAGS && outstanding[t]) else begin
                error_count++;
                $display("At time %0t the bus carried tag %0d, which has no result in flight",
                         $time, t);
            end
            if (int'(t) < NUM_TAGS && outstanding[t]) begin
                check_count++;
                assert (model_src1[t].ready && model_src2[t].ready) else begin
                    error_count++;
                    $display("At time %0t tag %0d completed before both operands were known",
                             $time, t);
                end
                expected = expected_result(model_op[t], model_src1[t].value,
                                           model_src2[t].value);
                check_count++;
                assert (cdb.value === expected) else begin
                    error_count++;
                    $display("ERROR time=%0t signal=cdb.value tag=%0d expected=%h actual=%h",
                             $time, t, expected, cdb.value);
                end
                // Dependents continue from the model value
                wake_sources(t, expected);
                outstanding[t] = 1'b0;
                broadcast_count++;
            end
        end
    endtask

    initial begin
        int drain_cycles;
        clk = 1'b0;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst_op = OP_ADD;
        inst_src1 = '0;
        inst_src2 = '0;
        lcg_state = 32'd32;
        error_count = 0;
        check_count = 0;
        strobe_count = 0;
        broadcast_count = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            outstanding[t] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        // Idle state right after reset
        @(negedge clk);
        check_count += 2;
        assert (cdb.valid === 1'b0) else begin
            error_count++;
            $display("ERROR time=%0t signal=cdb.valid expected=0 actual=%b", $time, cdb.valid);
        end
        assert (stall === 1'b0) else begin
            error_count++;
            $display("ERROR time=%0t signal=stall expected=0 actual=%b", $time, stall);
        end
        for (int cycle = 0; cycle < STIM_CYCLES; cycle++) begin
            @(posedge clk);
            #2;
            drive_inputs(1'b1);
            @(negedge clk);
            monitor_cycle();
        end
        // Stimulus is off while every result in flight drains
        drain_cycles = 0;
        while (count_outstanding() > 0 && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #2;
            drive_inputs(1'b0);
            @(negedge clk);
            monitor_cycle();
            drain_cycles++;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (outstanding[t]) begin
                error_count++;
                $display("Tag %0d was never broadcast before the drain timeout", t);
            end
        end
        // A second broadcast of a tag would show up on the quiet bus here
        for (int cycle = 0; cycle < IDLE_CYCLES; cycle++) begin
            @(negedge clk);
            monitor_cycle();
        end
        $display("Strobes %0d, broadcasts %0d, checks %0d, errors %0d",
                 strobe_count, broadcast_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
src/ooo_types_pkg.sv
src/tag_allocator.sv
src/dispatch_stage.sv
src/reservation_station.sv
src/alu_unit.sv
src/mult_unit.sv
src/writeback_arbiter.sv
src/ooo_issue_top.sv
sim/tb_ooo_issue_top.sv

//--- Bender.yml
package:
  name: ooo_issue

sources:
  - files:
      - src/ooo_types_pkg.sv
      - src/tag_allocator.sv
      - src/dispatch_stage.sv
      - src/reservation_station.sv
      - src/alu_unit.sv
      - src/mult_unit.sv
      - src/writeback_arbiter.sv
      - src/ooo_issue_top.sv
  - target: test
    files:
      - sim/tb_ooo_issue_top.sv
